// File: hw/baScoreboardPkg.sv
////////////////////////////////////////////////////////////
// Shared widths, window constants and FSM states for the
// receive-side Block Ack scoreboard, imported by every block
////////////////////////////////////////////////////////////

package baScoreboardPkg;

  ////////////////////////////////////////////////////////////
  // Sequence space
  ////////////////////////////////////////////////////////////

  // Sequence number field width
  parameter int unsigned baSnWidth = 12;

  // Half of the modulo-4096 sequence space
  // Upper bound of the "ahead of window" case
  parameter int unsigned baSnHalfSpace = 2048;

  ////////////////////////////////////////////////////////////
  // Window and bitmap
  ////////////////////////////////////////////////////////////

  // Only a 64-entry window is supported
  parameter int unsigned baWinSize = 64;

  // One bitmap bit per window position
  parameter int unsigned baBitmapWidth = baWinSize;

  ////////////////////////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////////////////////////

  // Read record, update it, write it back
  typedef enum logic [1:0] {
    idleSt   = 2'd0,
    readSt   = 2'd1,
    updateSt = 2'd2,
    writeSt  = 2'd3
  } baFsmStateT;

endpackage

// File: hw/scoreboardController.sv
////////////////////////////////////////////////////////////
// Partial-state scoreboard update for one Block Ack record
// Window case check, new SSN and bitmap, registered result
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module scoreboardController
  import baScoreboardPkg::*;
(
  input  logic                     macCoreClk,
  input  logic                     macCoreClkHardRst_n,
  input  logic                     macCoreClkSoftRst_n,
  // Frame type, high for BlockAckReq
  input  logic                     barRcved,
  input  logic [baSnWidth-1:0]     rxSN,
  input  logic [baSnWidth-1:0]     rxBASSN,
  // From FSM and record store
  input  logic                     startUpdate_p,
  input  logic [baBitmapWidth-1:0] readPSBitmap,
  input  logic [baSnWidth-1:0]     readSSN,
  input  logic                     newPsBitmap,
  input  logic                     baPSBitmapReset,
  // Result towards store and Block Ack builder
  output logic                     psBitmapUpdateDone_p,
  output logic [baBitmapWidth-1:0] updatedPSBitmap,
  output logic [baSnWidth-1:0]     updatedSSN,
  output logic [15:0]              debugPortBAController2
);

  // Shift amount must reach 64 so that a full shift clears
  localparam int shiftWidth = $clog2(baWinSize) + 1;
  localparam int idxWidth   = $clog2(baBitmapWidth);
  localparam logic [baSnWidth-1:0] winSizeSn   = baSnWidth'(baWinSize);
  localparam logic [baSnWidth-1:0] winLastSn   = baSnWidth'(baWinSize - 1);
  localparam logic [baSnWidth-1:0] halfSpaceSn = baSnWidth'(baSnHalfSpace);
  localparam logic [baBitmapWidth-1:0] topBit  = {1'b1, {(baBitmapWidth-1){1'b0}}};

  logic [baSnWidth-1:0]     muxSN;
  logic [baSnWidth-1:0]     diffSN1;
  logic [baSnWidth-1:0]     diffSN2;
  logic [baSnWidth-1:0]     mpduSSN;
  logic [shiftWidth-1:0]    diffSN1Sat;
  logic [shiftWidth-1:0]    diffSN2Sat;
  logic                     conditionCase1;
  logic                     conditionCase2;
  logic                     conditionCase3;
  logic [baSnWidth-1:0]     nextSSN;
  logic [baBitmapWidth-1:0] nextBitmap;

  ////////////////////////////////////////////////////////////
  // Window case classification
  ////////////////////////////////////////////////////////////

  // BAR compares its SSN, MPDU its own SN
  assign muxSN = barRcved ? rxBASSN : rxSN;

  // Offsets modulo 4096, so wrap-around needs no special case
  assign diffSN1 = muxSN - readSSN;
  // Distance past WinEnd
  assign diffSN2 = diffSN1 - winLastSn;

  // Case 1: WinStart <= SN <= WinEnd
  assign conditionCase1 = (diffSN1 < winSizeSn);
  // Case 2: WinEnd < SN < WinStart + 2048
  assign conditionCase2 = !conditionCase1 && (diffSN1 < halfSpaceSn);
  // Case 3: old frame, record untouched
  assign conditionCase3 = !conditionCase1 && !conditionCase2;

  // Saturate at window size, full shift empties the bitmap
  assign diffSN1Sat = conditionCase1 ? shiftWidth'(diffSN1) : shiftWidth'(baWinSize);
  assign diffSN2Sat = (diffSN2 >= winSizeSn) ? shiftWidth'(baWinSize) : shiftWidth'(diffSN2);

  // Window ending at SN
  assign mpduSSN = rxSN - winLastSn;

  ////////////////////////////////////////////////////////////
  // Next record value
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    nextSSN    = readSSN;
    nextBitmap = readPSBitmap;
    if (barRcved)
    begin
      // New record or case 2: window restarts empty at SSN
      if (newPsBitmap || conditionCase2)
      begin
        nextSSN    = rxBASSN;
        nextBitmap = '0;
      end
      else if (conditionCase1)
      begin
        // Slide window forward to the requested SSN
        nextSSN    = rxBASSN;
        nextBitmap = readPSBitmap >> diffSN1Sat;
      end
    end
    else
    begin
      if (newPsBitmap)
      begin
        // SN is WinEnd of a fresh record
        nextSSN    = mpduSSN;
        nextBitmap = topBit;
      end
      else if (conditionCase1)
        nextBitmap[diffSN1[idxWidth-1:0]] = 1'b1;
      else if (conditionCase2)
      begin
        // Drop the bits that fall out, SN lands on the top bit
        nextSSN    = mpduSSN;
        nextBitmap = (readPSBitmap >> diffSN2Sat) | topBit;
      end
    end
  end

  // Done one cycle after start
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      psBitmapUpdateDone_p <= 1'b0;
    else if (!macCoreClkSoftRst_n)
      psBitmapUpdateDone_p <= 1'b0;
    else
      psBitmapUpdateDone_p <= startUpdate_p;
  end

  // Result held until next update, zeroed on record clear
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      updatedSSN      <= '0;
      updatedPSBitmap <= '0;
    end
    else if (!macCoreClkSoftRst_n || baPSBitmapReset)
    begin
      updatedSSN      <= '0;
      updatedPSBitmap <= '0;
    end
    else if (startUpdate_p)
    begin
      updatedSSN      <= nextSSN;
      updatedPSBitmap <= nextBitmap;
    end
  end

  // Top two bits left free for the FSM state
  assign debugPortBAController2 = {2'b00, newPsBitmap, barRcved, diffSN1Sat[5:0],
                                   conditionCase3, conditionCase2, conditionCase1,
                                   startUpdate_p, psBitmapUpdateDone_p, baPSBitmapReset};

  // Soft reset must not swallow a started update
  doneFollowsStart: assert property (
    @(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    (startUpdate_p && macCoreClkSoftRst_n) |=> psBitmapUpdateDone_p
  );

endmodule

// File: hw/baRecordStore.sv
////////////////////////////////////////////////////////////
// Per-TID Block Ack record memory with valid flags
// Registered read port, write port and per-TID clear
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module baRecordStore
  import baScoreboardPkg::*;
#(
  parameter  int numTid   = 8,
  localparam int tidWidth = (numTid > 1) ? $clog2(numTid) : 1
)
(
  input  logic                     macCoreClk,
  input  logic                     macCoreClkHardRst_n,
  input  logic                     macCoreClkSoftRst_n,
  input  logic                     rdEn_p,
  input  logic [tidWidth-1:0]      rdTid,
  input  logic                     wrEn_p,
  input  logic [tidWidth-1:0]      wrTid,
  input  logic [baSnWidth-1:0]     wrSSN,
  input  logic [baBitmapWidth-1:0] wrBitmap,
  input  logic                     clearTid_p,
  input  logic [tidWidth-1:0]      clearTidIdx,
  output logic                     recValid,
  output logic [baSnWidth-1:0]     recSSN,
  output logic [baBitmapWidth-1:0] recBitmap
);

  logic [numTid-1:0]        slotValid;
  logic [baSnWidth-1:0]     ssnMem    [numTid];
  logic [baBitmapWidth-1:0] bitmapMem [numTid];
  // Slot of the last read and whether it was cleared since
  logic [tidWidth-1:0]      lastRdTid;
  logic                     rdSlotKilled;
  logic                     wrKeep;

  // Write-back of a cleared slot must not revive it
  assign wrKeep = !(rdSlotKilled && (wrTid == lastRdTid));

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      slotValid    <= '0;
      recValid     <= 1'b0;
      lastRdTid    <= '0;
      rdSlotKilled <= 1'b0;
    end
    else if (!macCoreClkSoftRst_n)
    begin
      slotValid    <= '0;
      recValid     <= 1'b0;
      lastRdTid    <= '0;
      rdSlotKilled <= 1'b0;
    end
    else
    begin
      if (rdEn_p)
      begin
        recValid     <= slotValid[rdTid];
        lastRdTid    <= rdTid;
        // Clear in the read cycle still returns the old flag
        rdSlotKilled <= clearTid_p && (clearTidIdx == rdTid);
      end
      else if (clearTid_p && (clearTidIdx == lastRdTid))
        rdSlotKilled <= 1'b1;
      if (wrEn_p && wrKeep)
        slotValid[wrTid] <= 1'b1;
      // Clear wins over a same-cycle write
      if (clearTid_p)
        slotValid[clearTidIdx] <= 1'b0;
    end
  end

  // Record payload
  always_ff @(posedge macCoreClk)
  begin
    if (rdEn_p)
    begin
      recSSN    <= ssnMem[rdTid];
      recBitmap <= bitmapMem[rdTid];
    end
    if (wrEn_p)
    begin
      ssnMem[wrTid]    <= wrSSN;
      bitmapMem[wrTid] <= wrBitmap;
    end
  end

  // TIDs from the FSM must address an existing slot
  tidInRange: assert property (
    @(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    (rdEn_p |-> (rdTid < numTid)) and (wrEn_p |-> (wrTid < numTid))
  );

endmodule

// File: hw/baControllerFsm.sv
////////////////////////////////////////////////////////////
// Block Ack controller FSM, one record update per event
// Read, update and write-back with busy and clear tracking
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module baControllerFsm
  import baScoreboardPkg::*;
#(
  parameter  int numTid   = 8,
  localparam int tidWidth = (numTid > 1) ? $clog2(numTid) : 1
)
(
  input  logic                macCoreClk,
  input  logic                macCoreClkHardRst_n,
  input  logic                macCoreClkSoftRst_n,
  // Receive event
  input  logic                rxEvent_p,
  input  logic [tidWidth-1:0] rxTid,
  // Record clear
  input  logic                clearTid_p,
  input  logic [tidWidth-1:0] clearTidIdx,
  // From scoreboard controller
  input  logic                psBitmapUpdateDone_p,
  // Record store control
  output logic                rdEn_p,
  output logic [tidWidth-1:0] rdTid,
  output logic                wrEn_p,
  output logic [tidWidth-1:0] wrTid,
  // Scoreboard controller control
  output logic                startUpdate_p,
  output logic                baPSBitmapReset,
  // Status
  output logic                baUpdateDone_p,
  output logic [tidWidth-1:0] baTid,
  output logic                baBusy,
  output baFsmStateT          fsmState
);

  baFsmStateT          stateQ;
  baFsmStateT          stateD;
  // TID of the event in flight
  logic [tidWidth-1:0] curTid;
  logic                accept;
  logic                clrMatch;
  // Clear seen for the in-flight TID
  logic                clrHit;

  // Events during an update are dropped
  assign accept   = rxEvent_p && (stateQ == idleSt) && !baBusy;
  assign clrMatch = clearTid_p && (clearTidIdx == curTid);

  ////////////////////////////////////////////////////////////
  // State sequencing
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    stateD = stateQ;
    case (stateQ)
      idleSt:   if (accept) stateD = readSt;
      readSt:   stateD = updateSt;
      updateSt: stateD = writeSt;
      writeSt:  stateD = idleSt;
      default:  stateD = idleSt;
    endcase
  end

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      stateQ         <= idleSt;
      rdEn_p         <= 1'b0;
      startUpdate_p  <= 1'b0;
      baUpdateDone_p <= 1'b0;
      baBusy         <= 1'b0;
      clrHit         <= 1'b0;
      curTid         <= '0;
    end
    else if (!macCoreClkSoftRst_n)
    begin
      stateQ         <= idleSt;
      rdEn_p         <= 1'b0;
      startUpdate_p  <= 1'b0;
      baUpdateDone_p <= 1'b0;
      baBusy         <= 1'b0;
      clrHit         <= 1'b0;
      curTid         <= '0;
    end
    else
    begin
      stateQ         <= stateD;
      rdEn_p         <= accept;
      startUpdate_p  <= (stateQ == readSt);
      baUpdateDone_p <= wrEn_p;
      // Busy from read through the done cycle
      if (accept)
        baBusy <= 1'b1;
      else if (baUpdateDone_p)
        baBusy <= 1'b0;
      if (accept)
      begin
        curTid <= rxTid;
        clrHit <= 1'b0;
      end
      else if ((stateQ != idleSt) && clrMatch)
        clrHit <= 1'b1;
    end
  end

  // Write back once the scoreboard result is registered
  assign wrEn_p = (stateQ == writeSt) && psBitmapUpdateDone_p;

  // Zero the result of a record cleared in flight
  assign baPSBitmapReset = (stateQ == writeSt) && (clrHit || clrMatch);

  assign rdTid    = curTid;
  assign wrTid    = curTid;
  assign baTid    = curTid;
  assign fsmState = stateQ;

  // Scoreboard start pulse tied to the update state
  startInUpdate: assert property (
    @(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    startUpdate_p |-> (stateQ == updateSt)
  );

endmodule

// File: hw/baController.sv
////////////////////////////////////////////////////////////
// Receive Block Ack scoreboard top, partial-state records
// Record store, controller FSM and scoreboard update logic
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module baController
  import baScoreboardPkg::*;
#(
  parameter  int numTid   = 8,
  localparam int tidWidth = (numTid > 1) ? $clog2(numTid) : 1
)
(
  input  logic                     macCoreClk,
  input  logic                     macCoreClkHardRst_n,
  input  logic                     macCoreClkSoftRst_n,
  // Receive event from the RX path
  input  logic                     rxEvent_p,
  input  logic                     barRcved,
  input  logic [tidWidth-1:0]      rxTid,
  input  logic [baSnWidth-1:0]     rxSN,
  input  logic [baSnWidth-1:0]     rxBASSN,
  // Record clear
  input  logic                     clearTid_p,
  input  logic [tidWidth-1:0]      clearTidIdx,
  // Towards Block Ack frame builder
  output logic                     baUpdateDone_p,
  output logic [tidWidth-1:0]      baTid,
  output logic [baSnWidth-1:0]     updatedSSN,
  output logic [baBitmapWidth-1:0] updatedPSBitmap,
  output logic                     baBusy,
  output logic [15:0]              debugPortBAController2
);

  logic                     rdEn_p;
  logic [tidWidth-1:0]      rdTid;
  logic                     wrEn_p;
  logic [tidWidth-1:0]      wrTid;
  logic                     recValid;
  logic [baSnWidth-1:0]     recSSN;
  logic [baBitmapWidth-1:0] recBitmap;
  logic                     startUpdate_p;
  logic                     baPSBitmapReset;
  logic                     psBitmapUpdateDone_p;
  logic [15:0]              sbDebug;
  baFsmStateT               fsmState;

  baRecordStore #(
    .numTid (numTid)
  ) uRecordStore (
    .macCoreClk, .macCoreClkHardRst_n, .macCoreClkSoftRst_n,
    .rdEn_p, .rdTid, .wrEn_p, .wrTid,
    .wrSSN      (updatedSSN),
    .wrBitmap   (updatedPSBitmap),
    .clearTid_p, .clearTidIdx,
    .recValid, .recSSN, .recBitmap
  );

  baControllerFsm #(
    .numTid (numTid)
  ) uControllerFsm (
    .macCoreClk, .macCoreClkHardRst_n, .macCoreClkSoftRst_n,
    .rxEvent_p, .rxTid, .clearTid_p, .clearTidIdx, .psBitmapUpdateDone_p,
    .rdEn_p, .rdTid, .wrEn_p, .wrTid, .startUpdate_p, .baPSBitmapReset,
    .baUpdateDone_p, .baTid, .baBusy, .fsmState
  );

  // Missing record means a new temporary record
  scoreboardController uScoreboard (
    .macCoreClk, .macCoreClkHardRst_n, .macCoreClkSoftRst_n,
    .barRcved, .rxSN, .rxBASSN, .startUpdate_p,
    .readPSBitmap (recBitmap),
    .readSSN      (recSSN),
    .newPsBitmap  (~recValid),
    .baPSBitmapReset, .psBitmapUpdateDone_p, .updatedPSBitmap, .updatedSSN,
    .debugPortBAController2 (sbDebug)
  );

  // FSM state in the free top bits
  assign debugPortBAController2 = sbDebug | {fsmState, 14'd0};

endmodule

// File: sim/baScoreboardRef.svh
////////////////////////////////////////////////////////////
// Reference Block Ack record model for the testbench
// Included inside the testbench module once numTid is set
////////////////////////////////////////////////////////////
`ifndef baScoreboardRefSvh
`define baScoreboardRefSvh

// Expected record state per TID
bit                       refValid  [numTid];
logic [baSnWidth-1:0]     refSsn    [numTid];
logic [baBitmapWidth-1:0] refBitmap [numTid];

// New SSN and bitmap after one MPDU or BAR
function automatic void computeRecord(
  input  bit                       isBar,
  input  logic [baSnWidth-1:0]     sn,
  input  bit                       known,
  input  logic [baSnWidth-1:0]     oldSsn,
  input  logic [baBitmapWidth-1:0] oldBitmap,
  output logic [baSnWidth-1:0]     newSsn,
  output logic [baBitmapWidth-1:0] newBitmap
);
  int spaceSize;
  int offset;
  int shift;
  spaceSize = 1 << baSnWidth;
  // Distance from window start, modulo the sequence space
  offset    = (int'(sn) - int'(oldSsn) + spaceSize) % spaceSize;
  newSsn    = oldSsn;
  newBitmap = oldBitmap;
  if (!known)
  begin
    // Temporary record
    newBitmap = '0;
    if (isBar)
      newSsn = sn;
    else
    begin
      newSsn = baSnWidth'(sn - (baWinSize - 1));
      newBitmap[baWinSize-1] = 1'b1;
    end
  end
  else if (offset < baWinSize)
  begin
    if (isBar)
    begin
      newSsn    = sn;
      newBitmap = oldBitmap >> offset;
    end
    else
      newBitmap[offset] = 1'b1;
  end
  else if (offset < baSnHalfSpace)
  begin
    if (isBar)
    begin
      newSsn    = sn;
      newBitmap = '0;
    end
    else
    begin
      // SN becomes the window end
      newSsn    = baSnWidth'(sn - (baWinSize - 1));
      shift     = (int'(newSsn) - int'(oldSsn) + spaceSize) % spaceSize;
      newBitmap = (shift >= baWinSize) ? '0 : (oldBitmap >> shift);
      newBitmap[baWinSize-1] = 1'b1;
    end
  end
  // Old frame, record unchanged
endfunction

`endif

// File: sim/baControllerTb.sv
////////////////////////////////////////////////////////////
// Testbench for the receive Block Ack scoreboard top
// Directed and random frames checked against a reference model
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module baControllerTb
  import baScoreboardPkg::*;
();

  localparam int numTid         = 8;
  localparam int tidWidth       = 3;
  localparam int clkPeriod      = 100;
  localparam int resetCycles    = 8;
  localparam int numDirected    = 23;
  localparam int numRandom      = 60;
  localparam int numEvents      = numDirected + numRandom;
  localparam int watchdogCycles = numEvents * 10 + resetCycles;

  logic                     macCoreClk;
  logic                     macCoreClkHardRst_n;
  logic                     macCoreClkSoftRst_n;
  logic                     rxEvent_p;
  logic                     barRcved;
  logic [tidWidth-1:0]      rxTid;
  logic [baSnWidth-1:0]     rxSN;
  logic [baSnWidth-1:0]     rxBASSN;
  logic                     clearTid_p;
  logic [tidWidth-1:0]      clearTidIdx;
  logic                     baUpdateDone_p;
  logic [tidWidth-1:0]      baTid;
  logic [baSnWidth-1:0]     updatedSSN;
  logic [baBitmapWidth-1:0] updatedPSBitmap;
  logic                     baBusy;
  logic [15:0]              debugPortBAController2;

  // Accepted event waiting for its done pulse
  bit                   pending    = 1'b0;
  int unsigned          pendCycle  = 0;
  bit                   pendBar;
  logic [tidWidth-1:0]  pendTid;
  logic [baSnWidth-1:0] pendSn;
  int unsigned          cycleCnt   = 0;
  int unsigned          doneCount  = 0;

  `include "baScoreboardRef.svh"

  baController #(
    .numTid (numTid)
  ) dut_i (
    .macCoreClk             (macCoreClk),
    .macCoreClkHardRst_n    (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n    (macCoreClkSoftRst_n),
    .rxEvent_p              (rxEvent_p),
    .barRcved               (barRcved),
    .rxTid                  (rxTid),
    .rxSN                   (rxSN),
    .rxBASSN                (rxBASSN),
    .clearTid_p             (clearTid_p),
    .clearTidIdx            (clearTidIdx),
    .baUpdateDone_p         (baUpdateDone_p),
    .baTid                  (baTid),
    .updatedSSN             (updatedSSN),
    .updatedPSBitmap        (updatedPSBitmap),
    .baBusy                 (baBusy),
    .debugPortBAController2 (debugPortBAController2)
  );

  always #(clkPeriod / 2) macCoreClk = ~macCoreClk;

  task automatic reportError(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "Stopping at first failed check");
  endtask

  // Controller state a given number of cycles after an accepted event
  function automatic baFsmStateT stateAfterEvent(input int unsigned cyclesSince);
    case (cyclesSince)
      1:       return readSt;
      2:       return updateSt;
      3:       return writeSt;
      default: return idleSt;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Comparison against the reference model
  ////////////////////////////////////////////////////////////

  // Outputs sampled mid-cycle
  always @(negedge macCoreClk)
  begin : compareBlock
    logic [baSnWidth-1:0]     expSsn;
    logic [baBitmapWidth-1:0] expBitmap;
    bit                       expBusy;
    baFsmStateT               expState;
    if (macCoreClkHardRst_n)
    begin
      cycleCnt++;
      // Busy from the read cycle through the done cycle
      expBusy  = pending;
      expState = pending ? stateAfterEvent(cycleCnt - pendCycle) : idleSt;
      assert (baBusy == expBusy)
      else reportError($sformatf("baBusy %0b, expected %0b", baBusy, expBusy));
      // Debug port carries FSM state and update pulses
      assert (debugPortBAController2[15:14] == expState)
      else reportError($sformatf("debug FSM state %0d, expected %0d",
                                 debugPortBAController2[15:14], expState));
      assert (debugPortBAController2[2:1] == {expState == updateSt, expState == writeSt})
      else reportError($sformatf("debug start and done bits %b, expected %b",
                                 debugPortBAController2[2:1],
                                 {expState == updateSt, expState == writeSt}));
      // Done due exactly 4 cycles after the accepted event
      if (pending && (cycleCnt == pendCycle + 4))
      begin
        assert (baUpdateDone_p)
        else reportError($sformatf("no update done 4 cycles after event on TID %0d", pendTid));
        computeRecord(pendBar, pendSn, refValid[pendTid], refSsn[pendTid],
                      refBitmap[pendTid], expSsn, expBitmap);
        assert (baTid == pendTid)
        else reportError($sformatf("baTid %0d, expected %0d", baTid, pendTid));
        assert (updatedSSN == expSsn)
        else reportError($sformatf("SSN %0d, expected %0d", updatedSSN, expSsn));
        assert (updatedPSBitmap == expBitmap)
        else reportError($sformatf("bitmap %h, expected %h", updatedPSBitmap, expBitmap));
        refValid[pendTid]  = 1'b1;
        refSsn[pendTid]    = expSsn;
        refBitmap[pendTid] = expBitmap;
        pending            = 1'b0;
        doneCount++;
      end
      else
        assert (!baUpdateDone_p)
        else reportError("update done pulse without an accepted event");
      if (!macCoreClkSoftRst_n)
        foreach (refValid[i])
          refValid[i] = 1'b0;
      if (clearTid_p)
        refValid[clearTidIdx] = 1'b0;
      // Events seen while busy are dropped
      if (rxEvent_p && !expBusy && macCoreClkSoftRst_n)
      begin
        pending   = 1'b1;
        pendCycle = cycleCnt;
        pendBar   = barRcved;
        pendTid   = rxTid;
        pendSn    = barRcved ? rxBASSN : rxSN;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // One frame, optionally with extra events while busy
  task automatic sendFrame(input bit isBar, input int tid, input int sn, input bit withDrops);
    int waitCycles;
    @(posedge macCoreClk);
    rxEvent_p <= 1'b1;
    barRcved  <= isBar;
    rxTid     <= tidWidth'(tid);
    rxSN      <= baSnWidth'(sn);
    rxBASSN   <= baSnWidth'(sn);
    waitCycles = 0;
    @(posedge macCoreClk);
    while (!baUpdateDone_p)
    begin
      // Frame fields held, only the TID moves
      rxEvent_p <= withDrops;
      rxTid     <= rxTid + 1'b1;
      waitCycles++;
      if (waitCycles > 20)
        reportError($sformatf("no update done within 20 cycles of frame on TID %0d", tid));
      @(posedge macCoreClk);
    end
    rxEvent_p <= 1'b0;
  endtask

  task automatic clearRecord(input int tid);
    @(posedge macCoreClk);
    clearTid_p  <= 1'b1;
    clearTidIdx <= tidWidth'(tid);
    @(posedge macCoreClk);
    clearTid_p  <= 1'b0;
  endtask

  task automatic pulseSoftReset();
    @(posedge macCoreClk);
    macCoreClkSoftRst_n <= 1'b0;
    @(posedge macCoreClk);
    macCoreClkSoftRst_n <= 1'b1;
  endtask

  initial
  begin : stimulusBlock
    int unsigned seedInit;
    int          tid;
    int          sn;
    bit          isBar;
    macCoreClk          = 1'b0;
    macCoreClkHardRst_n = 1'b0;
    macCoreClkSoftRst_n = 1'b1;
    rxEvent_p           = 1'b0;
    barRcved            = 1'b0;
    rxTid               = '0;
    rxSN                = '0;
    rxBASSN             = '0;
    clearTid_p          = 1'b0;
    clearTidIdx         = '0;
    seedInit = $urandom(32'hb8ec_f63d);
    repeat (resetCycles) @(posedge macCoreClk);
    macCoreClkHardRst_n <= 1'b1;
    @(posedge macCoreClk);
    assert (!baUpdateDone_p && !baBusy)
    else reportError("control outputs not low after reset");

    // New record, in-window bit, wrapped window near 4095
    sendFrame(0, 0, 100, 0);
    sendFrame(0, 0, 50, 0);
    sendFrame(0, 1, 10, 0);
    sendFrame(0, 1, 4050, 0);
    sendFrame(0, 1, 5, 0);
    // Ahead by a partial shift, old, ahead by a full shift, old
    sendFrame(0, 0, 120, 0);
    sendFrame(0, 0, 40, 0);
    sendFrame(0, 0, 2100, 0);
    sendFrame(0, 0, 30, 0);
    // BAR on new record, in window, ahead, old
    sendFrame(1, 2, 500, 0);
    sendFrame(0, 2, 510, 0);
    sendFrame(0, 2, 520, 0);
    sendFrame(1, 2, 505, 0);
    sendFrame(1, 2, 900, 0);
    sendFrame(1, 2, 100, 0);
    // Independent TIDs, clear, soft reset
    sendFrame(0, 3, 7, 0);
    sendFrame(0, 4, 7, 0);
    clearRecord(3);
    sendFrame(0, 3, 3000, 0);
    sendFrame(0, 4, 20, 0);
    pulseSoftReset();
    sendFrame(0, 4, 1000, 0);
    sendFrame(1, 0, 64, 0);
    // Extra events while busy
    sendFrame(0, 5, 300, 1);
    sendFrame(1, 5, 280, 1);

    // Random frames, mostly close to the current window
    for (int i = 0; i < numRandom; i++)
    begin
      tid   = $urandom_range(numTid - 1);
      isBar = ($urandom_range(3) == 0);
      if ($urandom_range(1) == 0)
        sn = (refValid[tid] ? int'(refSsn[tid]) : 0) + $urandom_range(130);
      else
        sn = $urandom_range(4095);
      if ($urandom_range(9) == 0)
        clearRecord(tid);
      sendFrame(isBar, tid, sn, $urandom_range(7) == 0);
    end

    repeat (4) @(posedge macCoreClk);
    if (doneCount == numEvents)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
    begin
      $display("%0d updates completed, %0d expected", doneCount, numEvents);
      $display("TEST FAILED");
      $fatal(1, "Wrong number of completed updates");
    end
  end

  // Hang guard
  initial
  begin
    #(watchdogCycles * clkPeriod);
    $display("Watchdog expired after %0d cycles, the run did not complete", watchdogCycles);
    $display("TEST FAILED");
    $fatal(1, "Simulation hang");
  end

endmodule

// File: baController.f
+incdir+sim
hw/baScoreboardPkg.sv
hw/scoreboardController.sv
hw/baRecordStore.sv
hw/baControllerFsm.sv
hw/baController.sv
sim/baControllerTb.sv

// File: Bender.yml
package:
  name: baController

sources:
  # RTL in compile order
  - files:
      - hw/baScoreboardPkg.sv
      - hw/scoreboardController.sv
      - hw/baRecordStore.sv
      - hw/baControllerFsm.sv
      - hw/baController.sv

  # Testbench
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/baControllerTb.sv
